// ==== hdl/fft_frame_pkg.sv ====
package fft_frame_pkg;

  // frame geometry for the radix-2 front end.
  localparam int n_samples = 8;
  localparam int sample_width = 32;
  localparam int index_width = 3;  // log2 of n_samples.

  // whole frames the buffer between the two halves can hold.
  localparam int fifo_depth = 2;

  // one input sample as it arrives on the stream.
  typedef logic [sample_width-1:0] sample_t;

  // element i is the sample that arrived i-th within the frame.
  typedef sample_t [n_samples-1:0] frame_t;

  // the deserializer fills slots in collect and offers the frame in hold.
  typedef enum logic {
    collect = 1'b0,
    hold    = 1'b1
  } deser_state_t;

  // the serializer waits for a frame in idle and unloads it in send.
  typedef enum logic {
    idle = 1'b0,
    send = 1'b1
  } ser_state_t;

endpackage

// ==== hdl/sample_deserializer.sv ====
`timescale 1ns/1ns

module sample_deserializer (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   in_val,
  output logic                   in_rdy,
  input  fft_frame_pkg::sample_t in_sample,

  output logic                   frame_val,
  input  logic                   frame_rdy,
  output fft_frame_pkg::frame_t  frame_data
);

  typedef logic [fft_frame_pkg::index_width-1:0] index_t;

  fft_frame_pkg::deser_state_t state;
  fft_frame_pkg::deser_state_t state_next;

  index_t count;  // slot the next accepted sample goes into.
  index_t count_next;

  logic [fft_frame_pkg::n_samples-1:0] slot_en;
  logic in_fire;
  logic frame_fire;
  logic last_slot;

  assign in_rdy    = (state == fft_frame_pkg::collect);
  assign frame_val = (state == fft_frame_pkg::hold);

  assign in_fire    = in_val && in_rdy;
  assign frame_fire = frame_val && frame_rdy;
  assign last_slot  = (count == index_t'(fft_frame_pkg::n_samples - 1));

  // one-hot write enable for the sample registers.
  assign slot_en = {{(fft_frame_pkg::n_samples - 1){1'b0}}, 1'b1} << count;

  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      fft_frame_pkg::collect: begin
        if (in_fire) begin
          count_next = count + index_t'(1);  // wraps to zero after the eighth slot.
          if (last_slot) begin
            state_next = fft_frame_pkg::hold;
          end
        end
      end
      fft_frame_pkg::hold: begin
        if (frame_fire) begin
          state_next = fft_frame_pkg::collect;
          count_next = '0;
        end
      end
      default: begin
        state_next = fft_frame_pkg::collect;
        count_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_frame_pkg::collect;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  // frame_data stays put in hold since in_rdy is low there.
  always_ff @(posedge clk) begin
    for (int i = 0; i < fft_frame_pkg::n_samples; i++) begin
      if (in_fire && slot_en[i]) begin
        frame_data[i] <= in_sample;
      end
    end
  end

endmodule

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ns

module frame_fifo (
  input  logic                  clk,
  input  logic                  reset,

  input  logic                  wr_val,
  output logic                  wr_rdy,
  input  fft_frame_pkg::frame_t wr_frame,

  output logic                  rd_val,
  input  logic                  rd_rdy,
  output fft_frame_pkg::frame_t rd_frame
);

  typedef logic [$clog2(fft_frame_pkg::fifo_depth)-1:0] ptr_t;
  typedef logic [$clog2(fft_frame_pkg::fifo_depth + 1)-1:0] level_t;

  fft_frame_pkg::frame_t mem [fft_frame_pkg::fifo_depth];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  level_t occupancy;  // frames currently stored, zero up to fifo_depth.

  logic wr_fire;
  logic rd_fire;

  assign wr_rdy = (occupancy < level_t'(fft_frame_pkg::fifo_depth));
  assign rd_val = (occupancy != '0);

  // the head entry is read straight out of the array.
  assign rd_frame = mem[rd_ptr];

  assign wr_fire = wr_val && wr_rdy;
  assign rd_fire = rd_val && rd_rdy;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    if (ptr == ptr_t'(fft_frame_pkg::fifo_depth - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_fire, rd_fire})
        2'b10:   occupancy <= occupancy + level_t'(1);
        2'b01:   occupancy <= occupancy - level_t'(1);
        default: occupancy <= occupancy;  // both or neither leave the level unchanged.
      endcase
    end
  end

  // a written frame is visible at rd_frame only from the next cycle.
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_frame;
    end
  end

endmodule

// ==== hdl/bitrev_serializer.sv ====
`timescale 1ns/1ns

module bitrev_serializer (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   frame_val,
  output logic                   frame_rdy,
  input  fft_frame_pkg::frame_t  frame_data,

  output logic                   out_val,
  input  logic                   out_rdy,
  output fft_frame_pkg::sample_t out_sample
);

  typedef logic [fft_frame_pkg::index_width-1:0] index_t;

  fft_frame_pkg::ser_state_t state;
  fft_frame_pkg::ser_state_t state_next;

  fft_frame_pkg::frame_t frame_q;  // local copy of the frame being unloaded.

  index_t pos;  // output position within the frame.
  index_t pos_next;
  index_t rev_pos;

  logic load;
  logic out_fire;
  logic last_pos;

  assign frame_rdy = (state == fft_frame_pkg::idle);
  assign out_val   = (state == fft_frame_pkg::send);

  assign load     = frame_val && frame_rdy;
  assign out_fire = out_val && out_rdy;
  assign last_pos = (pos == index_t'(fft_frame_pkg::n_samples - 1));

  // mirror the position bits so position 1 picks sample 4, and so on.
  always_comb begin
    for (int b = 0; b < fft_frame_pkg::index_width; b++) begin
      rev_pos[b] = pos[fft_frame_pkg::index_width - 1 - b];
    end
  end

  assign out_sample = frame_q[rev_pos];

  always_comb begin
    state_next = state;
    pos_next   = pos;
    case (state)
      fft_frame_pkg::idle: begin
        if (load) begin
          state_next = fft_frame_pkg::send;
          pos_next   = '0;
        end
      end
      fft_frame_pkg::send: begin
        if (out_fire) begin
          pos_next = pos + index_t'(1);
          if (last_pos) begin
            state_next = fft_frame_pkg::idle;
          end
        end
      end
      default: begin
        state_next = fft_frame_pkg::idle;
        pos_next   = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_frame_pkg::idle;
      pos   <= '0;
    end else begin
      state <= state_next;
      pos   <= pos_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= frame_data;
    end
  end

endmodule

// ==== hdl/frame_reorder_top.sv ====
`timescale 1ns/1ns

module frame_reorder_top (
  input  logic                                  clk,
  input  logic                                  reset,

  input  logic                                  in_val,
  output logic                                  in_rdy,
  input  logic [fft_frame_pkg::sample_width-1:0] in_sample,

  output logic                                  out_val,
  input  logic                                  out_rdy,
  output logic [fft_frame_pkg::sample_width-1:0] out_sample
);

  // deserializer to FIFO.
  logic                  frame_val;
  logic                  frame_rdy;
  fft_frame_pkg::frame_t frame_data;

  // FIFO to serializer.
  logic                  buf_val;
  logic                  buf_rdy;
  fft_frame_pkg::frame_t buf_data;

  sample_deserializer deser0 (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_sample  (in_sample),
    .frame_val  (frame_val),
    .frame_rdy  (frame_rdy),
    .frame_data (frame_data)
  );

  frame_fifo fifo0 (
    .clk      (clk),
    .reset    (reset),
    .wr_val   (frame_val),
    .wr_rdy   (frame_rdy),
    .wr_frame (frame_data),
    .rd_val   (buf_val),
    .rd_rdy   (buf_rdy),
    .rd_frame (buf_data)
  );

  bitrev_serializer ser0 (
    .clk        (clk),
    .reset      (reset),
    .frame_val  (buf_val),
    .frame_rdy  (buf_rdy),
    .frame_data (buf_data),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .out_sample (out_sample)
  );

endmodule

// ==== testbench/frame_reorder_assert.sv ====
`timescale 1ns/1ns

module frame_reorder_assert (
  input logic                                    clk,
  input logic                                    reset,
  input logic                                    in_val,
  input logic                                    in_rdy,
  input logic                                    frame_val,
  input logic                                    frame_rdy,
  input logic                                    out_val,
  input logic                                    out_rdy,
  input fft_frame_pkg::sample_t                  out_sample,
  input logic [fft_frame_pkg::index_width-1:0]   deser_count,
  input fft_frame_pkg::ser_state_t               ser_state
);

  logic [fft_frame_pkg::index_width:0] sent;  // transfers since the serializer left idle.

  always_ff @(posedge clk) begin
    if (reset || ser_state == fft_frame_pkg::idle) begin
      sent <= '0;
    end else if (out_val && out_rdy) begin
      sent <= sent + 1'b1;
    end
  end

  out_hold: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_sample)))
    else $error("out_val or out_sample changed while out_rdy was low");

  eighth_blocks: assert property (@(posedge clk) disable iff (reset)
    (in_val && in_rdy && deser_count == '1) |=> (!in_rdy && frame_val))
    else $error("in_rdy stayed high after the eighth sample of a frame");

  hold_blocks: assert property (@(posedge clk) disable iff (reset)
    (frame_val && !frame_rdy) |=> (frame_val && !in_rdy))
    else $error("a frame was dropped or in_rdy rose before the FIFO took the frame");

  send_length: assert property (@(posedge clk) disable iff (reset)
    (ser_state == fft_frame_pkg::send &&
     !(out_val && out_rdy && sent == (fft_frame_pkg::n_samples - 1)))
    |=> (ser_state == fft_frame_pkg::send))
    else $error("serializer left send before eight transfers");

  reset_quiet: assert property (@(posedge clk) reset |=> !out_val)
    else $error("out_val was high during reset");

endmodule

bind frame_reorder_top frame_reorder_assert assert0 (
  .clk         (clk),
  .reset       (reset),
  .in_val      (in_val),
  .in_rdy      (in_rdy),
  .frame_val   (frame_val),
  .frame_rdy   (frame_rdy),
  .out_val     (out_val),
  .out_rdy     (out_rdy),
  .out_sample  (out_sample),
  .deser_count (deser0.count),
  .ser_state   (ser0.state)
);

// ==== testbench/frame_reorder_tb.sv ====
`timescale 1ns/1ns

module frame_reorder_tb;

  localparam int n_rows = 10;
  localparam int clk_period = 40;
  localparam int reset_cycles = 10;
  localparam int total_samples = n_rows * fft_frame_pkg::n_samples;
  localparam int timeout_cycles = total_samples * 6 + reset_cycles;
  localparam int long_block = 8;  // in_rdy low this long means output back-pressure.

  logic clk;
  logic reset;
  logic in_val;
  logic in_rdy;
  logic out_val;
  logic out_rdy;
  fft_frame_pkg::sample_t in_sample;
  fft_frame_pkg::sample_t out_sample;

  // stimulus table, one frame per row.
  fft_frame_pkg::frame_t row_samples [n_rows];
  logic [7:0]            row_gaps [n_rows];    // bit i puts two idle cycles before sample i.
  logic [31:0]           row_stalls [n_rows];  // bit b holds out_rdy low for two cycles.

  fft_frame_pkg::sample_t expected_q [$];
  int     out_count;
  int     low_run;
  int     longest_low_run;
  integer seed;

  frame_reorder_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_sample  (in_sample),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .out_sample (out_sample)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: only %0d of %0d output samples arrived within %0d cycles",
             out_count, total_samples, timeout_cycles);
    $display("Test failed");
    $fatal(1);
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input fft_frame_pkg::sample_t exp,
                              input fft_frame_pkg::sample_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
    end
  endtask

  // output position p carries the input index with its three bits mirrored.
  function automatic int reversed_index(input int pos);
    return ((pos & 1) << 2) | (pos & 2) | ((pos >> 2) & 1);
  endfunction

  task automatic load_table();
    for (int i = 0; i < fft_frame_pkg::n_samples; i++) begin
      row_samples[0][i] = fft_frame_pkg::sample_t'(i);  // index-encoded.
      row_samples[1][i] = '0;
      row_samples[2][i] = '1;
    end
    for (int r = 3; r < n_rows; r++) begin
      for (int i = 0; i < fft_frame_pkg::n_samples; i++) begin
        row_samples[r][i] = $random(seed);
      end
    end
    row_gaps[0] = 8'h00;  row_stalls[0] = 32'hffff_ffff;  // long stall fills the pipe.
    row_gaps[1] = 8'h00;  row_stalls[1] = 32'h0000_0000;
    row_gaps[2] = 8'h00;  row_stalls[2] = 32'h0000_000c;
    row_gaps[3] = 8'h00;  row_stalls[3] = 32'h0000_0006;
    row_gaps[4] = 8'h02;  row_stalls[4] = 32'h0000_0000;
    row_gaps[5] = 8'ha5;  row_stalls[5] = 32'h0000_ffff;
    row_gaps[6] = 8'h00;  row_stalls[6] = 32'h0000_0005;
    row_gaps[7] = 8'h81;  row_stalls[7] = 32'h0000_0000;
    row_gaps[8] = 8'hff;  row_stalls[8] = 32'h0000_00ff;
    row_gaps[9] = 8'h10;  row_stalls[9] = 32'h0000_0000;
  endtask

  task automatic build_expected();
    for (int r = 0; r < n_rows; r++) begin
      for (int p = 0; p < fft_frame_pkg::n_samples; p++) begin
        expected_q.push_back(row_samples[r][reversed_index(p)]);
      end
    end
  endtask

  task automatic drive_rows();
    for (int r = 0; r < n_rows; r++) begin
      for (int i = 0; i < fft_frame_pkg::n_samples; i++) begin
        if (row_gaps[r][i]) begin
          repeat (2) begin
            @(negedge clk);
            in_val = 1'b0;
          end
        end
        @(negedge clk);
        in_val    = 1'b1;
        in_sample = row_samples[r][i];
        while (!in_rdy) @(negedge clk);  // transfer happens at the next rising edge.
      end
    end
    @(negedge clk);
    in_val = 1'b0;
  endtask

  // each row's mask starts once the frame before it has fully left the DUT.
  task automatic drive_out_rdy();
    for (int r = 0; r < n_rows; r++) begin
      wait (out_count >= r * fft_frame_pkg::n_samples);
      for (int c = 0; c < 64 && out_count < (r + 1) * fft_frame_pkg::n_samples; c++) begin
        @(negedge clk);
        out_rdy = ~row_stalls[r][c / 2];
      end
      out_rdy = 1'b1;
    end
  endtask

  // scoreboard. samples beyond the table only raise the count.
  always @(posedge clk) begin
    if (!reset && out_val && out_rdy) begin
      if (expected_q.size() != 0) begin
        check_sample("out_sample", expected_q.pop_front(), out_sample);
      end
      out_count++;
    end
  end

  // track how long the input side stays blocked.
  always @(negedge clk) begin
    if (!reset) begin
      if (!in_rdy) begin
        low_run++;
        if (low_run > longest_low_run) begin
          longest_low_run = low_run;
        end
      end else begin
        low_run = 0;
      end
    end
  end

  initial begin
    seed            = 32'h27431863;
    reset           = 1'b1;
    in_val          = 1'b0;
    in_sample       = '0;
    out_rdy         = 1'b0;
    out_count       = 0;
    low_run         = 0;
    longest_low_run = 0;
    load_table();
    build_expected();
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("in_rdy", 1'b1, in_rdy);
    check_flag("out_val", 1'b0, out_val);
    fork
      drive_rows();
      drive_out_rdy();
    join_none
    wait (out_count == total_samples);
    repeat (20) @(negedge clk);  // a duplicated sample would raise the count here.
    check_count("out_count", total_samples, out_count);
    if (longest_low_run < long_block) begin
      abort_run("in_rdy never stayed low while the output was stalled");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
hdl/fft_frame_pkg.sv
hdl/sample_deserializer.sv
hdl/frame_fifo.sv
hdl/bitrev_serializer.sv
hdl/frame_reorder_top.sv
testbench/frame_reorder_assert.sv
testbench/frame_reorder_tb.sv
